/* source/tile_pkg.sv */
// Tile memory package
package tile_pkg;

  // Bus widths
  typedef logic [31:0] addr_t;  // Byte address
  typedef logic [31:0] data_t;  // One data word
  typedef logic [3:0]  be_t;    // One enable bit per byte lane

  // Default geometry of the scratchpad
  localparam int unsigned DEF_N_BANKS      = 4;    // Word interleaved banks
  localparam int unsigned DEF_N_WORDS_BANK = 256;  // Depth of one bank

  // Address map
  localparam addr_t L1_ADDR_START = 32'h1000_0000;  // Scratchpad base
  localparam addr_t L2_ADDR_START = 32'h8000_0000;  // First L2 byte
  localparam addr_t L2_ADDR_END   = 32'h9000_0000;  // First byte past L2

  // Processor side in-flight tracking
  localparam int unsigned MAX_OUTSTANDING = 2;  // Transactions tracked by the demux

  typedef logic [$clog2(MAX_OUTSTANDING+1)-1:0] cnt_t;  // Outstanding counter

  // Decoded target of a processor request
  typedef enum logic [1:0] {
    TGT_L1,  // Banked scratchpad
    TGT_L2,  // External L2 port
    TGT_ERR  // Unmapped address
  } tgt_e;

endpackage

/* source/mem_port_if.sv */
// Memory port bundle
`timescale 1ns/1ns
interface mem_port_if
  import tile_pkg::*;
(
  input logic clk_i  // Tile clock of this port
);

  // Request side
  logic  req;     // Request strobe
  addr_t addr;    // Byte or word address
  logic  we;      // Write when high
  be_t   be;      // Byte enables
  data_t wdata;   // Write data
  logic  gnt;     // Request accepted

  // Response side
  logic  rvalid;  // One per granted request
  data_t rdata;   // Read data
  logic  err;     // Error response

  modport initiator (
    input  clk_i,
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport target (
    input  clk_i,
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

/* source/tile_clk_gate.sv */
// Tile clock gate
`timescale 1ns/1ns
module tile_clk_gate (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic enable_i,
  input  logic test_mode_i,
  output logic clk_o,
  output logic clk_en_o     // Next tile clock edge will occur
);

  logic en_q;      // Registered tile enable
  logic en_latch;  // Enable seen by the AND gate

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      en_q <= 1'b0;
    end else begin
      en_q <= enable_i;
    end
  end

  assign clk_en_o = en_q | test_mode_i;  // Test mode forces the clock on

  // Transparent while clk_i is low so the gate output cannot glitch
  always_latch begin
    if (!rstn_i) begin
      en_latch = 1'b0;
    end else if (!clk_i) begin
      en_latch = clk_en_o;
    end
  end

  assign clk_o = clk_i & en_latch;  // Gated system clock

endmodule

/* source/addr_demux.sv */
// Processor address demux
`timescale 1ns/1ns
module addr_demux
  import tile_pkg::*;
#(
  parameter int unsigned N_WORDS_BANK = DEF_N_WORDS_BANK,
  parameter int unsigned N_BANKS      = DEF_N_BANKS
)(
  input  logic  clk_i,
  input  logic  rstn_i,
  input  logic  clk_en_i,      // Tile clock runs on the next edge

  // Processor side
  input  logic  core_req_i,
  input  addr_t core_addr_i,
  input  logic  core_we_i,
  input  be_t   core_be_i,
  input  data_t core_wdata_i,
  output logic  core_gnt_o,
  output logic  core_rvalid_o,
  output data_t core_rdata_o,
  output logic  core_err_o,

  // Scratchpad side
  mem_port_if.initiator l1_o,

  // L2 side
  output logic  l2_req_o,
  output addr_t l2_addr_o,
  output logic  l2_we_o,
  output be_t   l2_be_o,
  output data_t l2_wdata_o,
  input  logic  l2_gnt_i,
  input  logic  l2_rvalid_i,
  input  data_t l2_rdata_i,
  input  logic  l2_err_i
);

  localparam addr_t L1_ADDR_END = L1_ADDR_START + addr_t'(N_BANKS * N_WORDS_BANK * 4);

  tgt_e tgt;        // Target of the current request
  tgt_e tgt_q;      // Target of transactions in flight
  cnt_t cnt_q;      // Transactions in flight
  logic stall;      // New request must wait
  logic tgt_gnt;    // Grant from the selected target
  logic accept;     // Request granted this cycle
  logic rsp_valid;  // Response from the target in flight
  logic done;       // Response returned this cycle
  logic err_q;      // Local error response pending

  // Two rule address map, anything else is an error
  always_comb begin
    if (core_addr_i >= L1_ADDR_START && core_addr_i < L1_ADDR_END) begin
      tgt = TGT_L1;
    end else if (core_addr_i >= L2_ADDR_START && core_addr_i < L2_ADDR_END) begin
      tgt = TGT_L2;
    end else begin
      tgt = TGT_ERR;
    end
  end

  // Keep responses in order by never mixing targets in flight
  assign stall = ~clk_en_i
               | (cnt_q == cnt_t'(MAX_OUTSTANDING))
               | ((cnt_q != '0) & (tgt != tgt_q));

  assign l1_o.req   = core_req_i & ~stall & (tgt == TGT_L1);
  assign l1_o.addr  = core_addr_i;
  assign l1_o.we    = core_we_i;
  assign l1_o.be    = core_be_i;
  assign l1_o.wdata = core_wdata_i;

  assign l2_req_o   = core_req_i & ~stall & (tgt == TGT_L2);  // Passed through unchanged
  assign l2_addr_o  = core_addr_i;
  assign l2_we_o    = core_we_i;
  assign l2_be_o    = core_be_i;
  assign l2_wdata_o = core_wdata_i;

  always_comb begin
    case (tgt)
      TGT_L1:  tgt_gnt = l1_o.gnt;
      TGT_L2:  tgt_gnt = l2_gnt_i;
      default: tgt_gnt = 1'b1;  // Error responder accepts at once
    endcase
  end

  assign accept     = core_req_i & ~stall & tgt_gnt;
  assign core_gnt_o = accept;

  // Response mux follows the target in flight
  always_comb begin
    rsp_valid    = 1'b0;
    core_rdata_o = '0;
    core_err_o   = 1'b0;
    case (tgt_q)
      TGT_L1: begin
        rsp_valid    = l1_o.rvalid;
        core_rdata_o = l1_o.rdata;
        core_err_o   = l1_o.err;
      end
      TGT_L2: begin
        rsp_valid    = l2_rvalid_i;
        core_rdata_o = l2_rdata_i;
        core_err_o   = l2_err_i;
      end
      default: begin
        rsp_valid  = err_q;  // Read data stays zero
        core_err_o = err_q;
      end
    endcase
  end

  assign done          = rsp_valid & (cnt_q != '0);  // Ignore strays with nothing in flight
  assign core_rvalid_o = done;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cnt_q <= '0;
      tgt_q <= TGT_L1;
      err_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + cnt_t'(accept) - cnt_t'(done);
      if (accept) begin
        tgt_q <= tgt;
      end
      err_q <= accept & (tgt == TGT_ERR);  // Error rvalid one cycle after grant
    end
  end

endmodule

/* source/l1_interconnect.sv */
// Scratchpad bank interconnect
`timescale 1ns/1ns
module l1_interconnect
  import tile_pkg::*;
#(
  parameter int unsigned N_BANKS      = DEF_N_BANKS,
  parameter int unsigned N_WORDS_BANK = DEF_N_WORDS_BANK
)(
  input  logic clk_i,
  input  logic rstn_i,
  input  logic clk_en_i,                     // Tile clock runs on the next edge
  mem_port_if.target    core_i,              // Processor initiator
  mem_port_if.target    acc_i,               // Accelerator initiator
  mem_port_if.initiator banks_o [N_BANKS]    // One port per bank
);

  localparam int unsigned BANK_W = $clog2(N_BANKS);
  localparam int unsigned WORD_W = $clog2(N_WORDS_BANK);

  typedef logic [BANK_W-1:0] bank_idx_t;  // Bank select
  typedef logic [WORD_W-1:0] word_idx_t;  // Word within a bank

  bank_idx_t          core_bank;
  bank_idx_t          acc_bank;
  word_idx_t          core_word;
  word_idx_t          acc_word;
  logic [N_BANKS-1:0] core_hit;      // Processor targets this bank
  logic [N_BANKS-1:0] acc_hit;       // Accelerator targets this bank
  logic [N_BANKS-1:0] win_acc;       // Accelerator wins this bank
  logic [N_BANKS-1:0] rr_q;          // Round robin, high favours the accelerator
  logic [N_BANKS-1:0] win_q;         // Winner of the previous cycle
  logic [N_BANKS-1:0] bank_gnt;
  logic [N_BANKS-1:0] bank_rvalid;
  logic [N_BANKS-1:0] bank_err;
  data_t              bank_rdata [N_BANKS];
  logic               core_rvalid;
  data_t              core_rdata;
  logic               core_err;
  logic               acc_rvalid;
  data_t              acc_rdata;
  logic               acc_err;

  // Word interleaving, bank from the bits just above the byte offset
  assign core_bank = core_i.addr[2 +: BANK_W];
  assign acc_bank  = acc_i.addr[2 +: BANK_W];
  assign core_word = core_i.addr[2+BANK_W +: WORD_W];
  assign acc_word  = acc_i.addr[2+BANK_W +: WORD_W];

  for (genvar b = 0; b < N_BANKS; b++) begin : gen_bank
    assign core_hit[b] = clk_en_i & core_i.req & (core_bank == bank_idx_t'(b));
    assign acc_hit[b]  = clk_en_i & acc_i.req & (acc_bank == bank_idx_t'(b));
    assign win_acc[b]  = acc_hit[b] & (~core_hit[b] | rr_q[b]);

    assign banks_o[b].req   = core_hit[b] | acc_hit[b];
    assign banks_o[b].addr  = win_acc[b] ? addr_t'(acc_word) : addr_t'(core_word);
    assign banks_o[b].we    = win_acc[b] ? acc_i.we : core_i.we;
    assign banks_o[b].be    = win_acc[b] ? acc_i.be : core_i.be;
    assign banks_o[b].wdata = win_acc[b] ? acc_i.wdata : core_i.wdata;

    // Flatten the bank responses for the return mux
    assign bank_gnt[b]    = banks_o[b].gnt;
    assign bank_rvalid[b] = banks_o[b].rvalid;
    assign bank_rdata[b]  = banks_o[b].rdata;
    assign bank_err[b]    = banks_o[b].err;
  end

  // Each initiator hits one bank at most so an OR is enough
  assign core_i.gnt = |(core_hit & ~win_acc & bank_gnt);
  assign acc_i.gnt  = |(acc_hit & win_acc & bank_gnt);

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rr_q  <= '0;
      win_q <= '0;
    end else begin
      rr_q  <= rr_q ^ (core_hit & acc_hit & bank_gnt);  // Flip after a contested grant
      win_q <= win_acc;                                  // Steers next cycle's rdata
    end
  end

  // Route read data back to the initiator that won last cycle
  always_comb begin
    core_rvalid = 1'b0;
    core_rdata  = '0;
    core_err    = 1'b0;
    acc_rvalid  = 1'b0;
    acc_rdata   = '0;
    acc_err     = 1'b0;
    for (int b = 0; b < N_BANKS; b++) begin
      if (bank_rvalid[b] && !win_q[b]) begin
        core_rvalid = 1'b1;
        core_rdata  = bank_rdata[b];
        core_err    = bank_err[b];
      end
      if (bank_rvalid[b] && win_q[b]) begin
        acc_rvalid = 1'b1;
        acc_rdata  = bank_rdata[b];
        acc_err    = bank_err[b];
      end
    end
  end

  assign core_i.rvalid = core_rvalid;
  assign core_i.rdata  = core_rdata;
  assign core_i.err    = core_err;
  assign acc_i.rvalid  = acc_rvalid;
  assign acc_i.rdata   = acc_rdata;
  assign acc_i.err     = acc_err;

endmodule

/* source/l1_spm.sv */
// Banked scratchpad memory
`timescale 1ns/1ns
module l1_spm
  import tile_pkg::*;
#(
  parameter int unsigned N_BANKS      = DEF_N_BANKS,
  parameter int unsigned N_WORDS_BANK = DEF_N_WORDS_BANK
)(
  input  logic clk_i,
  input  logic rstn_i,
  mem_port_if.target banks_i [N_BANKS]
);

  localparam int unsigned WORD_W = $clog2(N_WORDS_BANK);

  for (genvar b = 0; b < N_BANKS; b++) begin : gen_bank
    data_t             mem [N_WORDS_BANK] = '{default: '0};  // Zero at start of simulation
    logic [WORD_W-1:0] idx;       // Word within this bank
    logic              rvalid_q;
    data_t             rdata_q;

    assign idx            = banks_i[b].addr[WORD_W-1:0];
    assign banks_i[b].gnt = 1'b1;  // Single ported SRAM never stalls

    always_ff @(posedge clk_i) begin
      if (banks_i[b].req) begin
        if (banks_i[b].we) begin
          for (int i = 0; i < 4; i++) begin
            if (banks_i[b].be[i]) begin
              mem[idx][8*i +: 8] <= banks_i[b].wdata[8*i +: 8];  // Enabled lanes only
            end
          end
        end
        rdata_q <= mem[idx];  // Old word on a write
      end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
        rvalid_q <= 1'b0;
      end else begin
        rvalid_q <= banks_i[b].req;  // Reads and writes both answer
      end
    end

    assign banks_i[b].rvalid = rvalid_q;
    assign banks_i[b].rdata  = rdata_q;
    assign banks_i[b].err    = 1'b0;
  end

endmodule

/* source/spm_tile.sv */
// Accelerator tile memory
`timescale 1ns/1ns
module spm_tile
  import tile_pkg::*;
#(
  parameter int unsigned N_BANKS      = DEF_N_BANKS,       // Power of two
  parameter int unsigned N_WORDS_BANK = DEF_N_WORDS_BANK
)(
  input  logic  clk_i,
  input  logic  rstn_i,
  input  logic  test_mode_i,
  input  logic  tile_enable_i,

  // Processor data port
  input  logic  core_req_i,
  input  addr_t core_addr_i,
  input  logic  core_we_i,
  input  be_t   core_be_i,
  input  data_t core_wdata_i,
  output logic  core_gnt_o,
  output logic  core_rvalid_o,
  output data_t core_rdata_o,
  output logic  core_err_o,

  // Accelerator data port
  input  logic  acc_req_i,
  input  addr_t acc_addr_i,
  input  logic  acc_we_i,
  input  be_t   acc_be_i,
  input  data_t acc_wdata_i,
  output logic  acc_gnt_o,
  output logic  acc_rvalid_o,
  output data_t acc_rdata_o,

  // External L2 port
  output logic  l2_req_o,
  output addr_t l2_addr_o,
  output logic  l2_we_o,
  output be_t   l2_be_o,
  output data_t l2_wdata_o,
  input  logic  l2_gnt_i,
  input  logic  l2_rvalid_i,
  input  data_t l2_rdata_i,
  input  logic  l2_err_i
);

  logic sys_clk;     // Gated tile clock
  logic sys_clk_en;  // Tile clock runs on the next edge

  mem_port_if core_l1_if (.clk_i(sys_clk));
  mem_port_if acc_if (.clk_i(sys_clk));
  mem_port_if bank_if [N_BANKS] (.clk_i(sys_clk));

  // Accelerator pins straight onto its bundle
  assign acc_if.req    = acc_req_i;
  assign acc_if.addr   = acc_addr_i;
  assign acc_if.we     = acc_we_i;
  assign acc_if.be     = acc_be_i;
  assign acc_if.wdata  = acc_wdata_i;
  assign acc_gnt_o     = acc_if.gnt;
  assign acc_rvalid_o  = acc_if.rvalid;
  assign acc_rdata_o   = acc_if.rdata;

  tile_clk_gate i_clk_gate (
    .clk_i       ( clk_i         ),
    .rstn_i      ( rstn_i        ),
    .enable_i    ( tile_enable_i ),
    .test_mode_i ( test_mode_i   ),
    .clk_o       ( sys_clk       ),
    .clk_en_o    ( sys_clk_en    )
  );

  addr_demux #(
    .N_WORDS_BANK ( N_WORDS_BANK ),
    .N_BANKS      ( N_BANKS      )
  ) i_addr_demux (
    .clk_i         ( sys_clk       ),
    .rstn_i        ( rstn_i        ),
    .clk_en_i      ( sys_clk_en    ),
    .core_req_i    ( core_req_i    ),
    .core_addr_i   ( core_addr_i   ),
    .core_we_i     ( core_we_i     ),
    .core_be_i     ( core_be_i     ),
    .core_wdata_i  ( core_wdata_i  ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_rdata_o  ( core_rdata_o  ),
    .core_err_o    ( core_err_o    ),
    .l1_o          ( core_l1_if    ),
    .l2_req_o      ( l2_req_o      ),
    .l2_addr_o     ( l2_addr_o     ),
    .l2_we_o       ( l2_we_o       ),
    .l2_be_o       ( l2_be_o       ),
    .l2_wdata_o    ( l2_wdata_o    ),
    .l2_gnt_i      ( l2_gnt_i      ),
    .l2_rvalid_i   ( l2_rvalid_i   ),
    .l2_rdata_i    ( l2_rdata_i    ),
    .l2_err_i      ( l2_err_i      )
  );

  l1_interconnect #(
    .N_BANKS      ( N_BANKS      ),
    .N_WORDS_BANK ( N_WORDS_BANK )
  ) i_l1_interconnect (
    .clk_i    ( sys_clk    ),
    .rstn_i   ( rstn_i     ),
    .clk_en_i ( sys_clk_en ),
    .core_i   ( core_l1_if ),
    .acc_i    ( acc_if     ),
    .banks_o  ( bank_if    )
  );

  l1_spm #(
    .N_BANKS      ( N_BANKS      ),
    .N_WORDS_BANK ( N_WORDS_BANK )
  ) i_l1_spm (
    .clk_i   ( sys_clk ),
    .rstn_i  ( rstn_i  ),
    .banks_i ( bank_if )
  );

endmodule

/* test/tb_spm_tile.sv */
// Tile memory testbench
`timescale 1ns/1ns
module tb_spm_tile
  import tile_pkg::*;
();

  localparam int unsigned MAX_OPS = 64;  // Room for the stimulus file

  logic  clk_i;
  logic  rstn_i;
  logic  test_mode_i;
  logic  tile_enable_i;
  logic  core_req_i;
  addr_t core_addr_i;
  logic  core_we_i;
  be_t   core_be_i;
  data_t core_wdata_i;
  logic  core_gnt_o;
  logic  core_rvalid_o;
  data_t core_rdata_o;
  logic  core_err_o;
  logic  acc_req_i;
  addr_t acc_addr_i;
  logic  acc_we_i;
  be_t   acc_be_i;
  data_t acc_wdata_i;
  logic  acc_gnt_o;
  logic  acc_rvalid_o;
  data_t acc_rdata_o;
  logic  l2_req_o;
  addr_t l2_addr_o;
  logic  l2_we_o;
  be_t   l2_be_o;
  data_t l2_wdata_o;
  logic  l2_gnt_i;
  logic  l2_rvalid_i;
  data_t l2_rdata_i;
  logic  l2_err_i;

  // One entry per stimulus line
  byte   op_port  [MAX_OPS];
  logic  op_we    [MAX_OPS];
  addr_t op_addr  [MAX_OPS];
  be_t   op_be    [MAX_OPS];
  data_t op_wdata [MAX_OPS];
  data_t op_rdata [MAX_OPS];  // Expected read data
  logic  op_err   [MAX_OPS];  // Expected error flag
  int    n_ops = 0;
  logic  loaded = 1'b0;       // Starts the watchdog

  // L2 model state
  data_t       l2_mem [addr_t];
  int          l2_grants = 0;  // Requests accepted by the model
  addr_t       l2_seen_addr;   // Fields of the last accepted request
  logic        l2_seen_we;
  be_t         l2_seen_be;
  data_t       l2_seen_wdata;
  logic [31:0] lfsr = 32'hbfe8;

  spm_tile DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;  // 10 ns period
  end

  // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
    data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  function automatic int bank_of(input addr_t a);
    return int'((a >> 2) % DEF_N_BANKS);  // Word interleaved
  endfunction

  function automatic logic in_l2(input addr_t a);
    return (a >= L2_ADDR_START) && (a < L2_ADDR_END);
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (expected !== actual) begin
      stop_run($sformatf("error %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic load_stimulus();
    int                 fd;
    int                 code;
    byte                port;
    logic [8*256-1:0]   rest;  // Remainder of a comment line
    logic [31:0]        we, addr, be, wdata, rdata, err;
    fd = $fopen("test/spm_tile_stimulus.txt", "r");
    if (fd == 0) stop_run("cannot open test/spm_tile_stimulus.txt");
    while ($fscanf(fd, " %c", port) == 1) begin
      if (port == "#") begin
        code = $fgets(rest, fd);  // Skip the comment
      end else begin
        code = $fscanf(fd, " %h %h %h %h %h %h", we, addr, be, wdata, rdata, err);
        if (code != 6) stop_run($sformatf("stimulus entry %0d is malformed", n_ops));
        if (n_ops == MAX_OPS) stop_run("stimulus file has too many entries");
        op_port[n_ops]  = port;
        op_we[n_ops]    = we[0];
        op_addr[n_ops]  = addr;
        op_be[n_ops]    = be_t'(be);
        op_wdata[n_ops] = wdata;
        op_rdata[n_ops] = rdata;
        op_err[n_ops]   = err[0];
        n_ops++;
      end
    end
    $fclose(fd);
    loaded = 1'b1;
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after a rising edge
  task automatic drive_core(input int k, output data_t rdata, output logic err,
                            output int waits);
    waits        = 0;
    core_req_i   = 1'b1;
    core_addr_i  = op_addr[k];
    core_we_i    = op_we[k];
    core_be_i    = op_be[k];
    core_wdata_i = op_wdata[k];
    @(negedge clk_i);
    while (!core_gnt_o) begin
      waits++;              // Lost a grant opportunity
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1 core_req_i = 1'b0;
    @(negedge clk_i);
    while (!core_rvalid_o) @(negedge clk_i);
    rdata = core_rdata_o;
    err   = core_err_o;
    @(posedge clk_i);
    #1;
  endtask

  task automatic drive_acc(input int k, output data_t rdata, output int waits);
    waits       = 0;
    acc_req_i   = 1'b1;
    acc_addr_i  = op_addr[k];  // Offset into the scratchpad
    acc_we_i    = op_we[k];
    acc_be_i    = op_be[k];
    acc_wdata_i = op_wdata[k];
    @(negedge clk_i);
    while (!acc_gnt_o) begin
      waits++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1 acc_req_i = 1'b0;
    @(negedge clk_i);
    while (!acc_rvalid_o) @(negedge clk_i);
    rdata = acc_rdata_o;
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_core(input int k, input data_t rdata, input logic err,
                            input int l2_before);
    string t;
    t = $sformatf("op %0d core", k);
    if (!op_we[k]) compare_word({t, " rdata"}, op_rdata[k], rdata);
    compare_word({t, " err"}, op_err[k], err);
    compare_word({t, " l2 requests"}, in_l2(op_addr[k]), l2_grants - l2_before);
    if (in_l2(op_addr[k])) begin       // Forwarded unchanged
      compare_word({t, " l2 addr"}, op_addr[k], l2_seen_addr);
      compare_word({t, " l2 we"}, op_we[k], l2_seen_we);
      compare_word({t, " l2 be"}, op_be[k], l2_seen_be);
      compare_word({t, " l2 wdata"}, op_wdata[k], l2_seen_wdata);
    end
  endtask

  task automatic run_core(input int k);
    data_t rd;
    logic  er;
    int    waits;
    int    l2_before;
    l2_before = l2_grants;
    drive_core(k, rd, er, waits);
    check_core(k, rd, er, l2_before);
  endtask

  task automatic run_acc(input int k);
    data_t rd;
    int    waits;
    drive_acc(k, rd, waits);
    if (!op_we[k]) compare_word($sformatf("op %0d acc rdata", k), op_rdata[k], rd);
  endtask

  task automatic run_pair(input int k);
    data_t c_rd, a_rd;
    logic  c_er;
    int    c_waits, a_waits;
    int    l2_before;
    l2_before = l2_grants;
    fork
      drive_core(k, c_rd, c_er, c_waits);
      drive_acc(k + 1, a_rd, a_waits);
    join
    check_core(k, c_rd, c_er, l2_before);
    if (!op_we[k+1]) compare_word($sformatf("op %0d acc rdata", k + 1), op_rdata[k+1], a_rd);
    // Shared bank costs the loser one cycle, separate banks cost nothing
    compare_word($sformatf("op %0d pair waits", k),
                 (bank_of(op_addr[k]) == bank_of(op_addr[k+1])) ? 1 : 0, c_waits + a_waits);
  endtask

  task automatic run_gated(input int k);
    data_t rd;
    logic  er;
    int    waits;
    int    l2_before;
    l2_before     = l2_grants;
    tile_enable_i = 1'b0;
    repeat (2) @(posedge clk_i);  // Let the registered enable drop
    #1;
    fork
      drive_core(k, rd, er, waits);
      begin
        repeat (10) begin
          @(negedge clk_i);
          compare_word($sformatf("op %0d gnt while disabled", k), 0, core_gnt_o);
        end
        @(posedge clk_i);
        #1 tile_enable_i = 1'b1;
      end
    join
    check_core(k, rd, er, l2_before);
  endtask

  // L2 target, 0 to 3 cycles to grant and rvalid one cycle after
  initial begin
    logic [1:0] lat;
    l2_gnt_i    = 1'b0;
    l2_rvalid_i = 1'b0;
    l2_rdata_i  = '0;
    l2_err_i    = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;                                  // After the port drivers
      if (l2_req_o) begin
        for (int i = 0; i < 2; i++) begin
          lfsr = lfsr_step(lfsr);
          lat  = {lat[0], lfsr[0]};       // One step per bit
        end
        repeat (lat) begin
          @(posedge clk_i);
          #2;
        end
        l2_gnt_i      = 1'b1;
        l2_seen_addr  = l2_addr_o;
        l2_seen_we    = l2_we_o;
        l2_seen_be    = l2_be_o;
        l2_seen_wdata = l2_wdata_o;
        l2_grants++;
        @(posedge clk_i);
        #2 l2_gnt_i = 1'b0;
        l2_rdata_i = l2_mem.exists(l2_seen_addr) ? l2_mem[l2_seen_addr]
                                                 : l2_seen_addr ^ 32'hdead_beef;  // Fill
        if (l2_seen_we) l2_mem[l2_seen_addr] = merge_bytes(l2_rdata_i, l2_seen_wdata, l2_seen_be);
        l2_rvalid_i = 1'b1;
        @(posedge clk_i);
        #2 l2_rvalid_i = 1'b0;
      end
    end
  end

  initial begin
    wait (loaded);
    #(n_ops * 200 * 10);
    stop_run($sformatf("timeout, run did not finish within %0d cycles", n_ops * 200));
  end

  initial begin
    int k;
    rstn_i        = 1'b0;
    test_mode_i   = 1'b0;
    tile_enable_i = 1'b1;
    core_req_i    = 1'b0;
    core_addr_i   = '0;
    core_we_i     = 1'b0;
    core_be_i     = '0;
    core_wdata_i  = '0;
    acc_req_i     = 1'b0;
    acc_addr_i    = '0;
    acc_we_i      = 1'b0;
    acc_be_i      = '0;
    acc_wdata_i   = '0;
    load_stimulus();
    repeat (3) @(posedge clk_i);
    #1 rstn_i = 1'b1;
    repeat (3) @(posedge clk_i);  // Gated clock starts running
    #1;
    compare_word("reset handshake outputs", 0,
                 {core_gnt_o, core_rvalid_o, acc_gnt_o, acc_rvalid_o, l2_req_o});
    k = 0;
    while (k < n_ops) begin
      case (op_port[k])
        "c": run_core(k);
        "a": run_acc(k);
        "g": run_gated(k);
        "p": begin
          if (k + 1 >= n_ops || op_port[k+1] != "a") begin
            stop_run($sformatf("stimulus entry %0d pairs with no accelerator entry", k));
          end
          run_pair(k);
          k++;               // Partner line consumed
        end
        default: stop_run($sformatf("stimulus entry %0d has an unknown port", k));
      endcase
      k++;
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* test/spm_tile_stimulus.txt */
# port we addr be wdata exp_rdata exp_err, all hex except port
# port c core, a accelerator, p core paired with the next a line, g core while tile disabled
c 1 10000000 f 11223344 00000000 0
c 1 10000004 3 aabbccdd 00000000 0
c 1 10000004 c 55667788 00000000 0
c 1 10000008 5 deadbeef 00000000 0
c 0 10000000 f 00000000 11223344 0
c 0 10000004 f 00000000 5566ccdd 0
c 0 10000008 f 00000000 00ad00ef 0
a 1 00000040 f cafef00d 00000000 0
c 0 10000040 f 00000000 cafef00d 0
c 1 10000044 f 0badc0de 00000000 0
a 0 00000044 f 00000000 0badc0de 0
c 1 80000010 f 12345678 00000000 0
c 1 80000014 6 a1b2c3d4 00000000 0
c 0 80000010 f 00000000 12345678 0
c 0 80000014 f 00000000 5eb2c3fb 0
c 0 80000100 f 00000000 5eadbfef 0
c 1 80000000 f ffffffff 00000000 0
c 0 10000000 f 00000000 11223344 0
c 0 20000000 f 00000000 00000000 1
c 1 00000010 f 12121212 00000000 1
c 0 10001000 f 00000000 00000000 1
p 1 10000080 f 01010101 00000000 0
a 1 000000c0 f 02020202 00000000 0
p 0 100000c0 f 00000000 02020202 0
a 0 00000080 f 00000000 01010101 0
p 1 10000084 f 03030303 00000000 0
a 1 00000098 f 04040404 00000000 0
p 0 10000098 f 00000000 04040404 0
a 0 00000084 f 00000000 03030303 0
g 0 10000044 f 00000000 0badc0de 0

/* src.f */
source/tile_pkg.sv
source/mem_port_if.sv
source/tile_clk_gate.sv
source/addr_demux.sv
source/l1_interconnect.sv
source/l1_spm.sv
source/spm_tile.sv
test/tb_spm_tile.sv
